//--- game_timer.sv
`default_nettype none
`timescale 1ns/1ps

module game_timer import snake_pkg::*; (
    input  wire logic clk_pix, // pixel clock
    input  wire logic rst,     // sync reset, active high
    output      logic tick     // one cycle per game step
);

    typedef logic [$clog2(frame_cycles)-1:0] cyc_cnt_t; // cycle within frame
    typedef logic [$clog2(i_speed + 1)-1:0]  frm_cnt_t; // frame within tick period

    cyc_cnt_t cyc_cnt;    // stands in for the raster position
    frm_cnt_t frm_cnt;    // frames since the last tick
    logic     frame_end;  // last cycle of the frame
    logic     last_frame; // frame that carries the tick

    always_comb begin
        frame_end  = (cyc_cnt == cyc_cnt_t'(frame_cycles - 1));
        last_frame = (frm_cnt == frm_cnt_t'(i_speed));
    end

    // tick fires when both counters wrap together
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            cyc_cnt <= '0;
            frm_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            tick <= frame_end && last_frame; // single cycle pulse
            if (frame_end) begin
                cyc_cnt <= '0;
                frm_cnt <= last_frame ? '0 : frm_cnt + 1'b1; // skip i_speed frames
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- list.f
snake_pkg.sv
game_timer.sv
steer_decode.sv
snake_mover.sv
round_judge.sv
snake_game.sv
snake_game_sva.sv
tb_snake_game.sv

//--- round_judge.sv
`default_nettype none
`timescale 1ns/1ps

module round_judge import snake_pkg::*; (
    input  wire logic        clk_pix,     // pixel clock
    input  wire logic        rst,         // sync reset, active high
    input  wire logic        tick,        // game tick from the timer
    input  wire logic        start,       // start button level
    input  wire logic        wall_hit_p1, // p1 ran into the border
    input  wire logic        wall_hit_p2, // p2 ran into the border
    input  wire cell_x_t     head_p1_x,
    input  wire cell_x_t     head_p2_x,
    input  wire cell_y_t     head_p1_y,
    input  wire cell_y_t     head_p2_y,
    output      logic        step,        // movers advance one cell
    output      logic        load,        // movers and decoders reload
    output      game_state_t state,       // round state
    output      score_t      score_p1,
    output      score_t      score_p2
);

    game_state_t state_next;
    logic        start_prev;    // start level last cycle
    logic        start_rise;    // start went low to high
    logic        check;         // heads and wall hits of the last step are valid
    logic        head_on;       // both heads in one cell
    logic        coll_p1;       // p1 lost the round
    logic        coll_p2;       // p2 lost the round
    score_t      score_p1_next;
    score_t      score_p2_next;
    logic        win_reached;   // a new score equals win_score

    always_comb begin
        step       = tick && (state == play); // moves only happen in play
        load       = (state == position);
        start_rise = start && !start_prev;
    end

    // collision resolution one cycle after the step
    always_comb begin
        head_on = (head_p1_x == head_p2_x) && (head_p1_y == head_p2_y);
        coll_p1 = check && (wall_hit_p1 || head_on);
        coll_p2 = check && (wall_hit_p2 || head_on); // head-on costs both
        score_p1_next = score_p1 + score_t'(coll_p2); // point to the other player
        score_p2_next = score_p2 + score_t'(coll_p1);
        win_reached = (score_p1_next == score_t'(win_score))
                   || (score_p2_next == score_t'(win_score)); // uses the updated score
    end

    always_comb begin
        state_next = state;
        case (state)
            new_game: state_next = position;
            position: state_next = ready;
            ready: begin
                if (start_rise) begin
                    state_next = play;
                end
            end
            play: begin
                if (coll_p1 || coll_p2) begin
                    state_next = win_reached ? end_game : point;
                end
            end
            point: begin
                if (start_rise) begin
                    state_next = position; // next round, scores kept
                end
            end
            end_game: begin
                if (start_rise) begin
                    state_next = new_game;
                end
            end
            default: state_next = new_game;
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            state      <= new_game;
            start_prev <= 1'b0;
            check      <= 1'b0;
            score_p1   <= '0;
            score_p2   <= '0;
        end else begin
            state      <= state_next;
            start_prev <= start;
            check      <= step; // movers update on the same edge
            if (state == new_game) begin
                score_p1 <= '0;
                score_p2 <= '0;
            end else begin
                score_p1 <= score_p1_next; // unchanged without a collision
                score_p2 <= score_p2_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_snake_game -f list.f
./obj_dir/Vtb_snake_game | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"

//--- snake_game.sv
`default_nettype none
`timescale 1ns/1ps

module snake_game import snake_pkg::*; (
    input  wire logic        clk_pix,      // pixel clock
    input  wire logic        rst,          // sync reset, active high
    input  wire logic        btn_start,    // start or continue
    input  wire logic        btn_up_p1,    // player 1 buttons
    input  wire logic        btn_down_p1,
    input  wire logic        btn_left_p1,
    input  wire logic        btn_right_p1,
    input  wire logic        btn_up_p2,    // player 2 buttons
    input  wire logic        btn_down_p2,
    input  wire logic        btn_left_p2,
    input  wire logic        btn_right_p2,
    output      logic        tick,         // game tick
    output      game_state_t state,        // round state
    output      score_t      score_p1,
    output      score_t      score_p2,
    output      cell_x_t     head_p1_x,
    output      cell_y_t     head_p1_y,
    output      cell_x_t     head_p2_x,
    output      cell_y_t     head_p2_y
);

    logic step;        // one game step in play
    logic load;        // round setup
    dir_t dir_p1;
    dir_t dir_p2;
    logic wall_hit_p1;
    logic wall_hit_p2;

    game_timer timer_inst (
        .clk_pix,
        .rst,
        .tick
    );

    // p1 starts heading right, p2 heading left
    steer_decode #(.start_dir(right)) steer_p1_inst (
        .clk_pix,
        .rst,
        .step,
        .load,
        .btn_up    (btn_up_p1),
        .btn_down  (btn_down_p1),
        .btn_left  (btn_left_p1),
        .btn_right (btn_right_p1),
        .dir       (dir_p1)
    );

    steer_decode #(.start_dir(left)) steer_p2_inst (
        .clk_pix,
        .rst,
        .step,
        .load,
        .btn_up    (btn_up_p2),
        .btn_down  (btn_down_p2),
        .btn_left  (btn_left_p2),
        .btn_right (btn_right_p2),
        .dir       (dir_p2)
    );

    snake_mover #(.start_x(start_x_p1), .start_y(start_y)) mover_p1_inst (
        .clk_pix,
        .rst,
        .step,
        .load,
        .dir      (dir_p1),
        .head_x   (head_p1_x),
        .head_y   (head_p1_y),
        .wall_hit (wall_hit_p1)
    );

    snake_mover #(.start_x(start_x_p2), .start_y(start_y)) mover_p2_inst (
        .clk_pix,
        .rst,
        .step,
        .load,
        .dir      (dir_p2),
        .head_x   (head_p2_x),
        .head_y   (head_p2_y),
        .wall_hit (wall_hit_p2)
    );

    round_judge judge_inst (
        .clk_pix,
        .rst,
        .tick,
        .start (btn_start),
        .wall_hit_p1,
        .wall_hit_p2,
        .head_p1_x,
        .head_p2_x,
        .head_p1_y,
        .head_p2_y,
        .step,
        .load,
        .state,
        .score_p1,
        .score_p2
    );

endmodule

`default_nettype wire

//--- snake_game_sva.sv
`default_nettype none
`timescale 1ns/1ps

module snake_game_sva import snake_pkg::*; (
    input wire logic        clk_pix,
    input wire logic        rst,
    input wire logic        tick,
    input wire logic        step,
    input wire game_state_t state,
    input wire score_t      score_p1,
    input wire score_t      score_p2
);

    // heads only move in play and play follows ready
    step_in_play: assert property (@(posedge clk_pix) disable iff (rst)
        step |-> state == play && ($past(state) == ready || $past(state) == play))
        else $error("step outside play");

    // a step rides on a single cycle tick from the timer
    step_on_tick: assert property (@(posedge clk_pix) disable iff (rst)
        step |-> tick && !$past(tick))
        else $error("step without a fresh game tick");

    // game ends at win_score so nothing counts past it
    score_limit: assert property (@(posedge clk_pix) disable iff (rst)
        score_p1 <= score_t'(win_score) && score_p2 <= score_t'(win_score))
        else $error("score above win_score");

endmodule

bind round_judge snake_game_sva judge_sva_inst (
    .clk_pix (clk_pix),
    .rst     (rst),
    .tick    (tick),
    .step    (step),
    .state   (state),
    .score_p1(score_p1),
    .score_p2(score_p2)
);

`default_nettype wire

//--- snake_mover.sv
`default_nettype none
`timescale 1ns/1ps

module snake_mover import snake_pkg::*; #(
    parameter cell_x_t start_x = '0, // start column
    parameter cell_y_t start_y = '0  // start row
) (
    input  wire  logic    clk_pix,  // pixel clock
    input  wire  logic    rst,      // sync reset, active high
    input  wire  logic    step,     // move one cell now
    input  wire  logic    load,     // back to the start cell
    input  wire  dir_t    dir,      // heading held before this step
    output       cell_x_t head_x,   // head column
    output       cell_y_t head_y,   // head row
    output       logic    wall_hit  // pulse, step hit the border
);

    cell_x_t next_x;  // head column after the move
    cell_y_t next_y;  // head row after the move
    logic    at_edge; // move would leave the grid

    // one cell in dir, or hold at the border
    always_comb begin
        next_x  = head_x;
        next_y  = head_y;
        at_edge = 1'b0;
        case (dir)
            up: begin
                if (head_y == '0) begin
                    at_edge = 1'b1; // top row
                end else begin
                    next_y = head_y - 1'b1;
                end
            end
            down: begin
                if (head_y == cell_y_t'(v_cells - 1)) begin
                    at_edge = 1'b1; // bottom row
                end else begin
                    next_y = head_y + 1'b1;
                end
            end
            left: begin
                if (head_x == '0) begin
                    at_edge = 1'b1; // first column
                end else begin
                    next_x = head_x - 1'b1;
                end
            end
            right: begin
                if (head_x == cell_x_t'(h_cells - 1)) begin
                    at_edge = 1'b1; // last column
                end else begin
                    next_x = head_x + 1'b1;
                end
            end
            default: at_edge = 1'b0;
        endcase
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            head_x   <= start_x;
            head_y   <= start_y;
            wall_hit <= 1'b0;
        end else begin
            wall_hit <= step && at_edge; // lines up with the judge's check cycle
            if (load) begin
                head_x <= start_x;
                head_y <= start_y;
            end else if (step) begin
                head_x <= next_x; // unchanged on a wall hit
                head_y <= next_y;
            end
        end
    end

endmodule

`default_nettype wire

//--- snake_pkg.sv
`default_nettype none

package snake_pkg;

    // play field size in cells
    localparam int unsigned h_cells = 80; // grid columns
    localparam int unsigned v_cells = 60; // grid rows

    // game pacing
    localparam int unsigned frame_cycles = 16; // clk_pix cycles per frame, short for sim
    localparam int unsigned i_speed      = 2;  // frames skipped between ticks
    localparam int unsigned tick_cycles  = frame_cycles * (i_speed + 1); // cycles per tick

    localparam int unsigned win_score = 9; // first score to reach this ends the game

    // index and score widths
    typedef logic [6:0] cell_x_t; // column index, 0 .. h_cells-1
    typedef logic [5:0] cell_y_t; // row index, 0 .. v_cells-1
    typedef logic [3:0] score_t;  // one player's score

    // heading of a snake head
    typedef enum logic [1:0] {
        up,
        down,
        left,
        right
    } dir_t;

    // round state machine
    typedef enum logic [2:0] {
        new_game, // clear scores
        position, // heads to start cells
        ready,    // wait for start
        play,     // heads move on ticks
        point,    // round lost by someone
        end_game  // a player hit win_score
    } game_state_t;

    // start cells
    localparam cell_x_t start_x_p1 = 7'd5;  // left side
    localparam cell_x_t start_x_p2 = 7'd75; // right side
    localparam cell_y_t start_y    = 6'd30; // middle row, both players

endpackage

`default_nettype wire

//--- steer_decode.sv
`default_nettype none
`timescale 1ns/1ps

module steer_decode import snake_pkg::*; #(
    parameter dir_t start_dir = right // heading at the start of a round
) (
    input  wire logic clk_pix,   // pixel clock
    input  wire logic rst,       // sync reset, active high
    input  wire logic step,      // game step from the judge
    input  wire logic load,      // round setup
    input  wire logic btn_up,    // button levels, already clean
    input  wire logic btn_down,
    input  wire logic btn_left,
    input  wire logic btn_right,
    output      dir_t dir        // heading used by the mover
);

    logic [3:0] btn_now;   // right, left, up, down from msb down
    logic [3:0] btn_prev;  // levels seen at the previous step
    logic [3:0] btn_new;   // pressed since the previous step
    dir_t       dir_req;   // highest priority new press
    logic       req_valid; // some button was newly pressed
    logic       turn_ok;   // request is not a reversal

    // heading that would run the snake back into itself
    function automatic dir_t opposite(input dir_t d);
        case (d)
            up:      return down;
            down:    return up;
            left:    return right;
            default: return left;
        endcase
    endfunction

    always_comb begin
        btn_now = {btn_right, btn_left, btn_up, btn_down};
        btn_new = btn_now & ~btn_prev; // a held button counts once
    end

    // priority right, left, up, down
    always_comb begin
        req_valid = 1'b1;
        dir_req   = dir;
        if (btn_new[3]) begin
            dir_req = right;
        end else if (btn_new[2]) begin
            dir_req = left;
        end else if (btn_new[1]) begin
            dir_req = up;
        end else if (btn_new[0]) begin
            dir_req = down;
        end else begin
            req_valid = 1'b0;
        end
        turn_ok = req_valid && (dir_req != opposite(dir)); // no fallback to the next button
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            dir      <= start_dir;
            btn_prev <= '0;
        end else if (load) begin
            dir <= start_dir; // fresh round
        end else if (step) begin
            btn_prev <= btn_now; // sample once per step
            if (turn_ok) begin
                dir <= dir_req; // mover sees it on the next step
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_snake_game.sv
`default_nettype none
`timescale 1ns/1ps

module tb_snake_game import snake_pkg::*; ();

    localparam int clk_period  = 40;  // ns
    localparam int total_ticks = 302; // ticks used by all tests together
    localparam int spare_ticks = 20;  // room for start pulses and settling

    // button sets as {up, down, left, right}
    localparam logic [3:0] b_none  = 4'b0000;
    localparam logic [3:0] b_up    = 4'b1000;
    localparam logic [3:0] b_left  = 4'b0010;
    localparam logic [3:0] b_right = 4'b0001;

    logic        clk_pix = 1'b0;
    logic        rst;
    logic        btn_start;
    logic [3:0]  btn_p1;    // up, down, left, right
    logic [3:0]  btn_p2;
    logic        tick;
    game_state_t state;
    score_t      score_p1;
    score_t      score_p2;
    cell_x_t     head_p1_x;
    cell_y_t     head_p1_y;
    cell_x_t     head_p2_x;
    cell_y_t     head_p2_y;

    int errors = 0;
    int checks = 0;
    int exp_p1_x; // expected heads tracked from the movement rules
    int exp_p1_y;
    int exp_p2_x;
    int exp_s1;   // expected scores
    int exp_s2;

    snake_game dut0 (
        .clk_pix, .rst, .btn_start,
        .btn_up_p1 (btn_p1[3]), .btn_down_p1 (btn_p1[2]),
        .btn_left_p1 (btn_p1[1]), .btn_right_p1 (btn_p1[0]),
        .btn_up_p2 (btn_p2[3]), .btn_down_p2 (btn_p2[2]),
        .btn_left_p2 (btn_p2[1]), .btn_right_p2 (btn_p2[0]),
        .tick, .state, .score_p1, .score_p2,
        .head_p1_x, .head_p1_y, .head_p2_x, .head_p2_y
    );

    always #(clk_period / 2) clk_pix = ~clk_pix;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s expected 0x%0h got 0x%0h", name, expected, actual);
        end
    endtask

    task automatic check_game(input game_state_t exp_state);
        check("head_p1_x", exp_p1_x, 32'(head_p1_x));
        check("head_p1_y", exp_p1_y, 32'(head_p1_y));
        check("head_p2_x", exp_p2_x, 32'(head_p2_x));
        check("head_p2_y", int'(start_y), 32'(head_p2_y)); // p2 never turns
        check("score_p1", exp_s1, 32'(score_p1));
        check("score_p2", exp_s2, 32'(score_p2));
        check("state", 32'(exp_state), 32'(state));
    endtask

    task automatic start_heads();
        exp_p1_x = int'(start_x_p1);
        exp_p1_y = int'(start_y);
        exp_p2_x = int'(start_x_p2);
    endtask

    task automatic set_buttons(input logic [3:0] p1, input logic [3:0] p2);
        @(posedge clk_pix);
        btn_p1 <= p1;
        btn_p2 <= p2;
    endtask

    task automatic pulse_start();
        @(posedge clk_pix);
        btn_start <= 1'b1;
        @(posedge clk_pix);
        btn_start <= 1'b0; // judge saw the rising edge on this clock
    endtask

    // n ticks then two cycles for the move and the judge's check
    task automatic wait_ticks(input int n);
        repeat (n) begin
            @(negedge clk_pix);
            while (!tick) @(negedge clk_pix);
        end
        repeat (2) @(negedge clk_pix);
    endtask

    task automatic wait_state(input game_state_t target, input int max_cycles);
        int n = 0;
        do begin
            @(negedge clk_pix);
            n++;
        end while (state != target && n < max_cycles);
        check("state", 32'(target), 32'(state));
    endtask

    task automatic test_reset();
        wait_state(ready, 3); // new_game, position, ready
        start_heads();
        exp_s1 = 0;
        exp_s2 = 0;
        check_game(ready);
    endtask

    // width and spacing of the game tick
    task automatic test_tick();
        int n;
        @(negedge clk_pix);
        while (!tick) @(negedge clk_pix);
        @(negedge clk_pix);
        check("tick", 32'(0), 32'(tick)); // one cycle wide
        n = 1;
        while (!tick) begin
            @(negedge clk_pix);
            n++;
        end
        check("tick period", tick_cycles, n);
    endtask

    task automatic test_straight();
        pulse_start();
        wait_ticks(5);
        exp_p1_x += 5;
        exp_p2_x -= 5;
        check_game(play);
    endtask

    task automatic test_steering();
        set_buttons(b_up, b_right); // p2 asks for a reversal
        wait_ticks(1);              // turn taken while the old heading still moves
        exp_p1_x += 1;
        exp_p2_x -= 1;
        set_buttons(b_none, b_none);
        wait_ticks(1);
        exp_p1_y -= 1;
        exp_p2_x -= 1;
        check_game(play);
        set_buttons(b_up | b_left, b_none); // left wins while up stays held
        wait_ticks(1);
        exp_p1_y -= 1;
        exp_p2_x -= 1;
        set_buttons(b_up, b_none);
        wait_ticks(2); // held up must not turn again
        exp_p1_x -= 2;
        exp_p2_x -= 2;
        check_game(play);
    endtask

    task automatic test_wall();
        set_buttons(b_none, b_none);
        wait_ticks(1); // clears the held up level
        exp_p1_x -= 1;
        exp_p2_x -= 1;
        set_buttons(b_up, b_none);
        wait_ticks(1);
        exp_p1_x -= 1;
        exp_p2_x -= 1;
        set_buttons(b_none, b_none);
        wait_ticks(exp_p1_y); // climb to row 0
        exp_p2_x -= exp_p1_y;
        exp_p1_y = 0;
        check_game(play);
        wait_ticks(1); // into the top wall where the head holds
        exp_p2_x -= 1;
        exp_s2 += 1;
        check_game(point);
        pulse_start();
        wait_state(ready, 2);
        start_heads();
        check_game(ready);
    endtask

    task automatic test_head_on();
        pulse_start();
        wait_ticks(35); // both reach column 40
        exp_p1_x += 35;
        exp_p2_x -= 35;
        exp_s1 += 1;
        exp_s2 += 1;
        check_game(point);
    endtask

    task automatic test_game_end();
        while (exp_s2 < win_score) begin
            pulse_start(); // point to position
            wait_state(ready, 2);
            set_buttons(b_up, b_none);
            pulse_start();
            wait_ticks(1);
            set_buttons(b_none, b_none);
            wait_ticks(int'(start_y) + 1); // rows to the top and then the wall
            exp_p1_x = int'(start_x_p1) + 1;
            exp_p1_y = 0;
            exp_p2_x = int'(start_x_p2) - int'(start_y) - 2;
            exp_s2 += 1;
            check_game((exp_s2 == win_score) ? end_game : point);
        end
        pulse_start();
        @(negedge clk_pix);
        check("state", 32'(new_game), 32'(state));
        wait_state(ready, 3);
        start_heads();
        exp_s1 = 0;
        exp_s2 = 0;
        check_game(ready);
    endtask

    initial begin
        rst       = 1'b1;
        btn_start = 1'b0;
        btn_p1    = b_none;
        btn_p2    = b_none;
        repeat (4) @(posedge clk_pix);
        rst <= 1'b0;
        test_reset();
        test_tick();
        test_straight();
        test_steering();
        test_wall();
        test_head_on();
        test_game_end();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // whole tick budget plus spare in ns
    initial begin
        #((total_ticks + spare_ticks) * tick_cycles * clk_period);
        $display("timeout, the tests did not finish within %0d game ticks",
                 total_ticks + spare_ticks);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
